/* all.f */
rtl/uart_pkg.sv
rtl/reg_apb_bridge.sv
rtl/uart_regs.sv
rtl/sim_uart.sv
bench/tb_sim_uart.sv

/* Bender.yml */
package:
  name: sim_uart

sources:
  - rtl/uart_pkg.sv
  - rtl/reg_apb_bridge.sv
  - rtl/uart_regs.sv
  - rtl/sim_uart.sv
  - target: simulation
    files:
      - bench/tb_sim_uart.sv

/* bench/tb_sim_uart.sv */
// Testbench for the simulation UART
// Clock, reset, register bus tasks, reference register model,
// compare tasks and the directed and random test sequence

module tb_sim_uart;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned addr_width = 32;
  localparam int unsigned dw = uart_pkg::data_width;
  localparam int unsigned cw = uart_pkg::char_width;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  reg_valid_i;
  logic                  reg_write_i;
  logic [addr_width-1:0] reg_addr_i;
  logic [dw-1:0]         reg_wdata_i;
  logic                  reg_ready_o;
  logic [dw-1:0]         reg_rdata_o;
  logic                  reg_error_o;
  logic                  tx_valid_o;
  logic                  tx_first_o;
  logic [cw-1:0]         tx_data_o;

  // Reference register state
  logic [cw-1:0] model_regs [8];
  logic [cw-1:0] model_dll;
  logic [cw-1:0] model_dlm;
  logic          model_fifo_en;
  logic          model_start;

  // Expected characters as {first, char}, and captured strobes
  logic [cw:0]   exp_tx [$];
  logic [cw-1:0] cap_data [$];
  logic          cap_first [$];
  int            cap_cycle [$];

  int cycle_cnt = 0;
  int ready_cycle;
  int test_errors = 0;
  int total_errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  sim_uart #(
    .addr_width (addr_width)
  ) u_sim_uart (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_ready_o (reg_ready_o),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .tx_valid_o  (tx_valid_o),
    .tx_first_o  (tx_first_o),
    .tx_data_o   (tx_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Strobe capture, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni && tx_valid_o) begin
      cap_data.push_back(tx_data_o);
      cap_first.push_back(tx_first_o);
      cap_cycle.push_back(cycle_cnt);
    end
  end

  // ***********************************************************************
  // Reference model
  // ***********************************************************************

  function automatic logic [dw-1:0] ref_access(input logic wr, input logic [addr_width-1:0] addr,
                                               input logic [dw-1:0] wdata, output logic err);
    logic [2:0]    off;
    logic          dlab;
    logic [cw-1:0] c;
    logic [cw-1:0] val;
    off  = addr[4:2];
    dlab = model_regs[3][7];
    c    = wdata[7:0];
    val  = 8'h00;
    err  = |addr[addr_width-1:5];
    if (err) begin
      return '0;
    end
    if (wr) begin
      case (off)
        3'd0: begin
          if (dlab) begin
            model_dll = c;
          end else begin
            exp_tx.push_back({model_start, c});
            model_start = 1'b0;
          end
        end
        3'd1: begin
          if (dlab) model_dlm = c;
          else model_regs[1] = c & 8'h0F;
        end
        3'd2: model_fifo_en = wdata[0];
        3'd4: model_regs[4] = c & 8'h1F;
        default: model_regs[off] = c;
      endcase
    end else begin
      case (off)
        3'd0: val = dlab ? model_dll : 8'h00;
        3'd1: val = dlab ? model_dlm : model_regs[1];
        3'd2: val = model_fifo_en ? 8'hC0 : 8'h00;
        // THRE and TEMT always set
        3'd5: val = model_regs[5] | 8'h60;
        default: val = model_regs[off];
      endcase
    end
    return {{(dw - cw){1'b0}}, val};
  endfunction

  // ***********************************************************************
  // Compare tasks
  // ***********************************************************************

  task automatic note_failure();
    test_errors++;
    total_errors++;
  endtask

  task automatic check_rdata(input logic [dw-1:0] exp, input logic [dw-1:0] act);
    if (act !== exp) begin
      $display("Error at %0d ns: reg_rdata_o expected %h, actual %h", $time, exp, act);
      note_failure();
    end
  endtask

  task automatic check_char(input logic [cw-1:0] exp, input logic exp_first,
                            input logic [cw-1:0] act, input logic act_first);
    if (act !== exp) begin
      $display("Error at %0d ns: tx_data_o expected %h, actual %h", $time, exp, act);
      note_failure();
    end
    if (act_first !== exp_first) begin
      $display("Error at %0d ns: tx_first_o expected %b, actual %b", $time, exp_first, act_first);
      note_failure();
    end
  endtask

  task automatic check_error(input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0d ns: reg_error_o expected %b, actual %b", $time, exp, act);
      note_failure();
    end
  endtask

  // ***********************************************************************
  // Bus and transmit tasks
  // ***********************************************************************

  task automatic bus_access(input logic wr, input logic [addr_width-1:0] addr,
                            input logic [dw-1:0] wdata, output logic [dw-1:0] rdata,
                            output logic err, output logic ok);
    int waited;
    ok     = 1'b0;
    rdata  = '0;
    err    = 1'b0;
    waited = 0;
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_write_i <= wr;
    reg_addr_i  <= addr;
    reg_wdata_i <= wdata;
    while (!ok && waited < 20) begin
      @(negedge clk_i);
      if (reg_ready_o) begin
        ok          = 1'b1;
        rdata       = reg_rdata_o;
        err         = reg_error_o;
        ready_cycle = cycle_cnt;
      end
      waited++;
    end
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    if (!ok) begin
      $display("Bus access to address %h got no ready within 20 cycles", addr);
      note_failure();
    end
  endtask

  // Match captured strobes against expected characters
  task automatic check_tx();
    logic [cw:0] exp;
    int          waited;
    int          delay;
    while (exp_tx.size() > 0) begin
      exp    = exp_tx.pop_front();
      waited = 0;
      while (cap_data.size() == 0 && waited < 50) begin
        @(posedge clk_i);
        waited++;
      end
      if (cap_data.size() == 0) begin
        $display("No transmit strobe for character %h within 50 cycles", exp[cw-1:0]);
        note_failure();
      end else begin
        check_char(exp[cw-1:0], exp[cw], cap_data.pop_front(), cap_first.pop_front());
        delay = cap_cycle.pop_front() - ready_cycle;
        if (delay != 1) begin
          $display("Transmit strobe came %0d cycles after ready instead of 1", delay);
          note_failure();
        end
      end
    end
    repeat (2) @(posedge clk_i);
    if (cap_data.size() != 0) begin
      $display("Unexpected transmit strobe with character %h", cap_data[0]);
      note_failure();
      cap_data.delete();
      cap_first.delete();
      cap_cycle.delete();
    end
  endtask

  task automatic transfer(input logic wr, input logic [addr_width-1:0] addr,
                          input logic [dw-1:0] wdata);
    logic [dw-1:0] exp_rdata;
    logic [dw-1:0] act_rdata;
    logic          exp_err;
    logic          act_err;
    logic          ok;
    exp_rdata = ref_access(wr, addr, wdata, exp_err);
    bus_access(wr, addr, wdata, act_rdata, act_err, ok);
    if (ok) begin
      check_error(exp_err, act_err);
      if (!wr) begin
        check_rdata(exp_rdata, act_rdata);
      end
      check_tx();
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("Test %s: ok", name);
      tests_passed++;
    end else begin
      $display("Test %s: %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // ***********************************************************************
  // Test sequence
  // ***********************************************************************

  initial begin
    string                 msg;
    int                    seed;
    logic [31:0]           rnd;
    logic [addr_width-1:0] addr;
    seed          = 32'hac1c;
    msg           = "Hi UART";
    rst_ni        = 1'b0;
    reg_valid_i   <= 1'b0;
    reg_write_i   <= 1'b0;
    reg_addr_i    <= '0;
    reg_wdata_i   <= '0;
    foreach (model_regs[i]) model_regs[i] = 8'h00;
    model_dll     = 8'h00;
    model_dlm     = 8'h00;
    model_fifo_en = 1'b0;
    model_start   = 1'b1;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Plain registers, LSR with status bits on top
    transfer(1'b1, 32'h0C, 32'h03);
    transfer(1'b1, 32'h18, 32'hA5);
    transfer(1'b1, 32'h1C, 32'h5A);
    transfer(1'b1, 32'h14, 32'h11);
    transfer(1'b0, 32'h0C, 32'h0);
    transfer(1'b0, 32'h18, 32'h0);
    transfer(1'b0, 32'h1C, 32'h0);
    transfer(1'b0, 32'h14, 32'h0);
    finish_test("readback");

    transfer(1'b1, 32'h04, 32'hFF);
    transfer(1'b1, 32'h10, 32'hFF);
    transfer(1'b0, 32'h04, 32'h0);
    transfer(1'b0, 32'h10, 32'h0);
    transfer(1'b1, 32'h08, 32'h01);
    transfer(1'b0, 32'h08, 32'h0);
    transfer(1'b1, 32'h08, 32'h00);
    transfer(1'b0, 32'h08, 32'h0);
    finish_test("masks and IIR");

    // Divisor latch selected, no strobe expected
    transfer(1'b1, 32'h0C, 32'h83);
    transfer(1'b1, 32'h00, 32'h34);
    transfer(1'b1, 32'h04, 32'h12);
    transfer(1'b0, 32'h00, 32'h0);
    transfer(1'b0, 32'h04, 32'h0);
    transfer(1'b1, 32'h0C, 32'h03);
    transfer(1'b0, 32'h04, 32'h0);
    transfer(1'b0, 32'h00, 32'h0);
    finish_test("divisor latch");

    for (int i = 0; i < msg.len(); i++) begin
      transfer(1'b1, 32'h00, {24'h0, msg[i]});
    end
    finish_test("transmit string");

    transfer(1'b1, 32'h20, 32'h77);
    transfer(1'b1, 32'h8000_001C, 32'hEE);
    transfer(1'b1, 32'h0000_012C, 32'h80);
    transfer(1'b0, 32'h40, 32'h0);
    transfer(1'b0, 32'h1C, 32'h0);
    transfer(1'b0, 32'h0C, 32'h0);
    transfer(1'b0, 32'h04, 32'h0);
    finish_test("out of window");

    for (int i = 0; i < 200; i++) begin
      rnd  = $random(seed);
      addr = {27'h0, rnd[2:0], 2'b00};
      if (rnd[5:4] == 2'b00) begin
        addr[addr_width-1:5] = {rnd[31:8], 3'b001};
      end
      transfer(rnd[3], addr, $random(seed));
    end
    finish_test("random");

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (total_errors == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* rtl/sim_uart.sv */
// Simulation UART top level
// Register bus to APB bridge feeding the 16550-style register model

module sim_uart #(
  parameter int unsigned addr_width = 32
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Register bus
  input  logic                             reg_valid_i,
  input  logic                             reg_write_i,
  input  logic [addr_width-1:0]            reg_addr_i,
  input  logic [uart_pkg::data_width-1:0]  reg_wdata_i,
  output logic                             reg_ready_o,
  output logic [uart_pkg::data_width-1:0]  reg_rdata_o,
  output logic                             reg_error_o,
  // Transmitted characters
  output logic                             tx_valid_o,
  output logic                             tx_first_o,
  output logic [uart_pkg::char_width-1:0]  tx_data_o
);

  // APB between bridge and register model
  logic                            apb_psel;
  logic                            apb_penable;
  logic                            apb_pwrite;
  logic [addr_width-1:0]           apb_paddr;
  logic [uart_pkg::data_width-1:0] apb_pwdata;
  logic [uart_pkg::data_width-1:0] apb_prdata;
  logic                            apb_pready;
  logic                            apb_pslverr;

  reg_apb_bridge #(
    .addr_width (addr_width)
  ) u_reg_apb_bridge (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .reg_valid_i   (reg_valid_i),
    .reg_write_i   (reg_write_i),
    .reg_addr_i    (reg_addr_i),
    .reg_wdata_i   (reg_wdata_i),
    .reg_ready_o   (reg_ready_o),
    .reg_rdata_o   (reg_rdata_o),
    .reg_error_o   (reg_error_o),
    .apb_psel_o    (apb_psel),
    .apb_penable_o (apb_penable),
    .apb_pwrite_o  (apb_pwrite),
    .apb_paddr_o   (apb_paddr),
    .apb_pwdata_o  (apb_pwdata),
    .apb_prdata_i  (apb_prdata),
    .apb_pready_i  (apb_pready),
    .apb_pslverr_i (apb_pslverr)
  );

  uart_regs #(
    .addr_width (addr_width)
  ) u_uart_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .psel_i     (apb_psel),
    .penable_i  (apb_penable),
    .pwrite_i   (apb_pwrite),
    .paddr_i    (apb_paddr),
    .pwdata_i   (apb_pwdata),
    .prdata_o   (apb_prdata),
    .pready_o   (apb_pready),
    .pslverr_o  (apb_pslverr),
    .tx_valid_o (tx_valid_o),
    .tx_first_o (tx_first_o),
    .tx_data_o  (tx_data_o)
  );

endmodule

/* rtl/uart_regs.sv */
// 16550-style UART register model on APB
// Eight-register map with divisor latch alias, IER/MCR masks and fixed LSR status
// A THR write leaves as a one-cycle transmit strobe with a first-character flag

module uart_regs #(
  parameter int unsigned addr_width = 32
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // APB slave
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [addr_width-1:0]            paddr_i,
  input  logic [uart_pkg::data_width-1:0]  pwdata_i,
  output logic [uart_pkg::data_width-1:0]  prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  // Transmit output
  output logic                             tx_valid_o,
  output logic                             tx_first_o,
  output logic [uart_pkg::char_width-1:0]  tx_data_o
);

  localparam int unsigned idx_width = uart_pkg::window_bits - 2;

  // Register state
  logic [uart_pkg::char_width-1:0] lcr_q;
  logic [uart_pkg::char_width-1:0] dll_q;
  logic [uart_pkg::char_width-1:0] dlm_q;
  logic [uart_pkg::char_width-1:0] mcr_q;
  logic [uart_pkg::char_width-1:0] lsr_q;
  logic [uart_pkg::char_width-1:0] ier_q;
  logic [uart_pkg::char_width-1:0] msr_q;
  logic [uart_pkg::char_width-1:0] scr_q;
  logic                            fifo_en_q;
  logic                            start_q;

  // Transmit strobe
  logic                            tx_valid_q;
  logic                            tx_first_q;
  logic [uart_pkg::char_width-1:0] tx_data_q;

  // Decode
  logic                            access;
  logic                            in_window;
  logic                            wr_en;
  logic                            rd_en;
  logic                            dlab;
  logic                            tx_fire;
  logic [idx_width-1:0]            idx;
  logic [uart_pkg::char_width-1:0] wr_char;
  logic [uart_pkg::char_width-1:0] rd_char;

  // ***********************************************************************
  // Address decode
  // ***********************************************************************

  assign access    = psel_i & penable_i;
  assign in_window = ~|paddr_i[addr_width-1:uart_pkg::window_bits];
  assign idx       = paddr_i[uart_pkg::window_bits-1:2];
  assign wr_en     = access & pwrite_i & in_window;
  assign rd_en     = access & ~pwrite_i & in_window;
  assign dlab      = lcr_q[uart_pkg::lcr_dlab_bit];
  assign wr_char   = pwdata_i[uart_pkg::char_width-1:0];

  // Character goes out on THR writes with the divisor latch deselected
  assign tx_fire = wr_en && (idx == uart_pkg::off_thr) && !dlab;

  // Zero wait states and errors only outside the register window
  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~in_window;

  // ***********************************************************************
  // Register writes
  // ***********************************************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lcr_q     <= '0;
      dll_q     <= '0;
      dlm_q     <= '0;
      mcr_q     <= '0;
      lsr_q     <= '0;
      ier_q     <= '0;
      msr_q     <= '0;
      scr_q     <= '0;
      fifo_en_q <= 1'b0;
      start_q   <= 1'b1;
    end else if (wr_en) begin
      unique case (idx)
        uart_pkg::off_thr: begin
          if (dlab) begin
            dll_q <= wr_char;
          end else begin
            start_q <= 1'b0;
          end
        end
        uart_pkg::off_ier: begin
          if (dlab) begin
            dlm_q <= wr_char;
          end else begin
            ier_q <= wr_char & uart_pkg::ier_mask;
          end
        end
        // FCR only selects what IIR reports
        uart_pkg::off_iir: begin
          fifo_en_q <= pwdata_i[uart_pkg::fcr_enable_bit];
        end
        uart_pkg::off_lcr: begin
          lcr_q <= wr_char;
        end
        uart_pkg::off_mcr: begin
          mcr_q <= wr_char & uart_pkg::mcr_mask;
        end
        uart_pkg::off_lsr: begin
          lsr_q <= wr_char;
        end
        uart_pkg::off_msr: begin
          msr_q <= wr_char;
        end
        uart_pkg::off_scr: begin
          scr_q <= wr_char;
        end
        default: begin
        end
      endcase
    end
  end

  // ***********************************************************************
  // Transmit strobe
  // ***********************************************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_valid_q <= 1'b0;
      tx_first_q <= 1'b0;
    end else begin
      tx_valid_q <= tx_fire;
      // Start flag is still set during the first THR write
      tx_first_q <= tx_fire & start_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_fire) begin
      tx_data_q <= wr_char;
    end
  end

  assign tx_valid_o = tx_valid_q;
  assign tx_first_o = tx_first_q;
  assign tx_data_o  = tx_data_q;

  // ***********************************************************************
  // Register reads
  // ***********************************************************************

  always_comb begin
    rd_char = '0;
    if (rd_en) begin
      unique case (idx)
        // RBR reads zero as there is no receiver
        uart_pkg::off_thr: begin
          if (dlab) begin
            rd_char = dll_q;
          end
        end
        uart_pkg::off_ier: begin
          rd_char = dlab ? dlm_q : ier_q;
        end
        uart_pkg::off_iir: begin
          rd_char = fifo_en_q ? uart_pkg::iir_fifo_value : '0;
        end
        uart_pkg::off_lcr: begin
          rd_char = lcr_q;
        end
        uart_pkg::off_mcr: begin
          rd_char = mcr_q;
        end
        // Transmitter always reported empty
        uart_pkg::off_lsr: begin
          rd_char                         = lsr_q;
          rd_char[uart_pkg::lsr_thre_bit] = 1'b1;
          rd_char[uart_pkg::lsr_temt_bit] = 1'b1;
        end
        uart_pkg::off_msr: begin
          rd_char = msr_q;
        end
        uart_pkg::off_scr: begin
          rd_char = scr_q;
        end
        default: begin
        end
      endcase
    end
  end

  assign prdata_o = {{(uart_pkg::data_width - uart_pkg::char_width){1'b0}}, rd_char};

  // ***********************************************************************
  // Assertions
  // ***********************************************************************

  assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    penable_i |-> psel_i
  ) else $error("APB access phase without psel");

endmodule

/* rtl/reg_apb_bridge.sv */
// Register bus to APB bridge
// Three-state FSM (idle, setup, access) runs one APB transfer per request
// and returns ready, read data and error in the access cycle

module reg_apb_bridge #(
  parameter int unsigned addr_width = 32
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Register bus from the master
  input  logic                             reg_valid_i,
  input  logic                             reg_write_i,
  input  logic [addr_width-1:0]            reg_addr_i,
  input  logic [uart_pkg::data_width-1:0]  reg_wdata_i,
  output logic                             reg_ready_o,
  output logic [uart_pkg::data_width-1:0]  reg_rdata_o,
  output logic                             reg_error_o,
  // APB towards the slave
  output logic                             apb_psel_o,
  output logic                             apb_penable_o,
  output logic                             apb_pwrite_o,
  output logic [addr_width-1:0]            apb_paddr_o,
  output logic [uart_pkg::data_width-1:0]  apb_pwdata_o,
  input  logic [uart_pkg::data_width-1:0]  apb_prdata_i,
  input  logic                             apb_pready_i,
  input  logic                             apb_pslverr_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } state_e;

  state_e state_q;
  state_e state_d;

  logic xfer_done;

  // ***********************************************************************
  // Transfer sequencing
  // ***********************************************************************

  // Access phase completes once the slave reports ready
  assign xfer_done = (state_q == st_access) && apb_pready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_idle: begin
        if (reg_valid_i) begin
          state_d = st_setup;
        end
      end
      // Setup lasts exactly one cycle
      st_setup: begin
        state_d = st_access;
      end
      // Hold the access phase for slow slaves
      st_access: begin
        if (apb_pready_i) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // ***********************************************************************
  // APB request side
  // ***********************************************************************

  assign apb_psel_o    = (state_q != st_idle);
  assign apb_penable_o = (state_q == st_access);

  // Master holds the request stable, so it can drive APB directly
  assign apb_pwrite_o = reg_write_i;
  assign apb_paddr_o  = reg_addr_i;
  assign apb_pwdata_o = reg_wdata_i;

  // ***********************************************************************
  // Bus response side
  // ***********************************************************************

  assign reg_ready_o = xfer_done;
  assign reg_rdata_o = xfer_done ? apb_prdata_i : '0;
  assign reg_error_o = xfer_done & apb_pslverr_i;

  // ***********************************************************************
  // Assertions
  // ***********************************************************************

  // A pending request must not change under the bridge
  assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (reg_valid_i && !reg_ready_o) |=> ($stable(reg_addr_i) && $stable(reg_write_i))
  ) else $error("register request changed before ready");

endmodule

/* rtl/uart_pkg.sv */
// Shared constants for the simulation UART
// Bus and character widths, 16550 register word offsets,
// register bit positions, write masks and the register window size

package uart_pkg;

  // ***********************************************************************
  // Widths
  // ***********************************************************************

  // Register bus and APB data width
  localparam int unsigned data_width = 32;
  // One UART character, also the width of every register
  localparam int unsigned char_width = 8;

  // ***********************************************************************
  // Register word offsets, taken from address bits 4 to 2
  // ***********************************************************************

  // THR on write, RBR on read, DLL with DLAB set
  localparam logic [2:0] off_thr = 3'd0;
  // IER, DLM with DLAB set
  localparam logic [2:0] off_ier = 3'd1;
  // IIR on read, FCR on write
  localparam logic [2:0] off_iir = 3'd2;
  localparam logic [2:0] off_lcr = 3'd3;
  localparam logic [2:0] off_mcr = 3'd4;
  localparam logic [2:0] off_lsr = 3'd5;
  localparam logic [2:0] off_msr = 3'd6;
  localparam logic [2:0] off_scr = 3'd7;

  // ***********************************************************************
  // Bit positions, masks and fixed values
  // ***********************************************************************

  // Divisor latch access bit in LCR
  localparam int unsigned lcr_dlab_bit   = 7;
  // Transmit holding register empty
  localparam int unsigned lsr_thre_bit   = 5;
  // Transmitter empty
  localparam int unsigned lsr_temt_bit   = 6;
  // FIFO enable in FCR
  localparam int unsigned fcr_enable_bit = 0;

  // Writable bits of IER and MCR
  localparam logic [char_width-1:0] ier_mask = 8'h0F;
  localparam logic [char_width-1:0] mcr_mask = 8'h1F;

  // IIR value while the FIFOs are enabled, IIR reads zero otherwise
  localparam logic [char_width-1:0] iir_fifo_value = 8'hC0;

  // Register window is 32 bytes, any address bit at or above this is out of range
  localparam int unsigned window_bits = 5;

endpackage
